// File: bwt_ext_pkg.sv
// --------------------
// BWT backward extension types
// widths, latencies, request and result words, byte count function
// --------------------
package bwt_ext_pkg;

	// --------------------
	// widths and latencies
	// --------------------
	localparam int W_IDX       = 64;
	localparam int W_OCC       = 32;
	localparam int N_BASE      = 4;
	localparam int OCC_LATENCY = 7;
	localparam int OK_LATENCY  = 5;

	// one bi-interval of the FM-index
	typedef struct packed {
		logic [W_IDX-1:0] x0;
		logic [W_IDX-1:0] x1;
		logic [W_IDX-1:0] x2;
	} bi_interval_t;

	// occurrence checkpoint for a 128-base block
	// half h (16 bases) lives in bwt[h/2][32*(h%2) +: 32], first base in the top bits
	typedef struct packed {
		logic [N_BASE-1:0][W_OCC-1:0] cnt;
		logic [3:0][63:0]             bwt;
	} occ_ckpt_t;

	// one extension request, query base travels along
	typedef struct packed {
		logic [W_IDX-1:0] k;
		logic [W_IDX-1:0] l;
		bi_interval_t     ik;
		occ_ckpt_t        ckpt_k;
		occ_ckpt_t        ckpt_l;
		logic [1:0]       sel;
	} ext_req_t;

	// four extended intervals plus the selected one
	typedef struct packed {
		bi_interval_t [N_BASE-1:0] ok;
		bi_interval_t              target;
	} ext_res_t;

	// occurrence word, summed as a whole, read back per base
	// lane 0 is A, lanes never carry into each other for 128 bases
	typedef union packed {
		logic [W_OCC-1:0]       total;
		logic [N_BASE-1:0][7:0] lane;
	} occ_word_u;

	// host write, addr 0 primary, addr 1..4 L2 counts 0..3
	typedef struct packed {
		logic             valid;
		logic [2:0]       addr;
		logic [W_IDX-1:0] data;
	} cfg_wr_t;

	// counts of each base among the four 2-bit symbols of a byte
	function automatic occ_word_u byte_base_count(input logic [7:0] b);
		occ_word_u r;
		r.total = '0;
		for (int i = 0; i < 4; i++) begin
			r.lane[b[2*i +: 2]] = r.lane[b[2*i +: 2]] + 8'd1;
		end
		return r;
	endfunction

endpackage

// File: ext_config.sv
// --------------------
// extension config registers
// sentinel row and cumulative L2 base counts, written by address
// --------------------
module ext_config import bwt_ext_pkg::*; (
	input  logic                         Clk_32UI,
	input  logic                         reset_BWT_extend,
	input  cfg_wr_t                      cfg,
	output logic [W_IDX-1:0]             primary,
	output logic [N_BASE-1:0][W_IDX-1:0] l2
);

	localparam logic [2:0] ADDR_PRIMARY = 3'd0;
	localparam logic [2:0] ADDR_L2_LAST = 3'd4;

	// L2 slot for addresses 1..4
	logic [1:0] l2_idx;
	logic       l2_hit;

	assign l2_idx = 2'(cfg.addr - 3'd1);
	assign l2_hit = (cfg.addr != ADDR_PRIMARY) && (cfg.addr <= ADDR_L2_LAST);

	// --------------------
	// register file
	// --------------------
	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			primary <= '0;
			l2      <= '0;
		end else if (cfg.valid) begin
			if (cfg.addr == ADDR_PRIMARY) begin
				primary <= cfg.data;
			end else if (l2_hit) begin
				l2[l2_idx] <= cfg.data;
			end
			// addresses 5..7 are ignored
		end
	end

endmodule

// File: occ4_count.sv
// --------------------
// four-base occurrence count
// counts A/C/G/T up to a bound in a 128-base block in 7 stages
// --------------------
module occ4_count import bwt_ext_pkg::*; (
	input  logic                         Clk_32UI,
	input  logic [W_IDX-1:0]             bound,
	input  occ_ckpt_t                    ckpt,
	output logic [N_BASE-1:0][W_OCC-1:0] occ
);

	// selected half and position inside it
	logic [2:0]  half;
	logic [3:0]  low;
	logic [31:0] half_word;
	logic [31:0] mask;

	// word 0 holds the masked bound half and words 1..7 halves 0..6
	logic [7:0][31:0] s1_word;
	logic [W_OCC-1:0] s2_pair [8][2];
	logic [W_OCC-1:0] s3_quad [8];
	logic [W_OCC-1:0] s4_pair [4];
	logic [W_OCC-1:0] s4_even [4];
	logic [W_OCC-1:0] s5_pre  [8];
	occ_word_u        s6_sum;
	occ_word_u        s7_adj;

	// bound bits and checkpoint counts riding along
	logic [6:0]                   pos_q [6];
	logic [N_BASE-1:0][W_OCC-1:0] cnt_q [6];

	assign half      = bound[6:4];
	assign low       = bound[3:0];
	assign half_word = ckpt.bwt[half[2:1]][{half[0], 5'd0} +: 32];

	// keep bases 0..low and zero (A) the later ones
	assign mask = ~((32'd1 << {~low, 1'b0}) - 32'd1);

	// --------------------
	// stage 1 word select
	// --------------------
	always_ff @(posedge Clk_32UI) begin
		s1_word[0] <= half_word & mask;
		for (int h = 0; h < 7; h++) begin
			s1_word[h+1] <= ckpt.bwt[h/2][(h%2)*32 +: 32];
		end
	end

	always_ff @(posedge Clk_32UI) begin
		pos_q[0] <= bound[6:0];
		cnt_q[0] <= ckpt.cnt;
		for (int i = 1; i < 6; i++) begin
			pos_q[i] <= pos_q[i-1];
			cnt_q[i] <= cnt_q[i-1];
		end
	end

	// --------------------
	// stages 2..5 adder tree
	// --------------------
	always_ff @(posedge Clk_32UI) begin
		for (int g = 0; g < 8; g++) begin
			for (int j = 0; j < 2; j++) begin
				s2_pair[g][j] <= byte_base_count(s1_word[g][16*j +: 8]) +
					byte_base_count(s1_word[g][16*j+8 +: 8]);
			end
		end
	end

	always_ff @(posedge Clk_32UI) begin
		for (int g = 0; g < 8; g++) begin
			s3_quad[g] <= s2_pair[g][0] + s2_pair[g][1];
		end
	end

	always_ff @(posedge Clk_32UI) begin
		for (int i = 0; i < 4; i++) begin
			s4_pair[i] <= s3_quad[2*i] + s3_quad[2*i+1];
			s4_even[i] <= s3_quad[2*i];
		end
	end

	// prefix sums over the low and the high four groups
	always_ff @(posedge Clk_32UI) begin
		for (int s = 0; s < 2; s++) begin
			s5_pre[4*s]   <= s4_even[2*s];
			s5_pre[4*s+1] <= s4_pair[2*s];
			s5_pre[4*s+2] <= s4_pair[2*s] + s4_even[2*s+1];
			s5_pre[4*s+3] <= s4_pair[2*s] + s4_pair[2*s+1];
		end
	end

	// --------------------
	// stage 6 prefix select
	// --------------------
	always_ff @(posedge Clk_32UI) begin
		if (pos_q[4][6]) begin
			s6_sum.total <= s5_pre[3] + s5_pre[pos_q[4][6:4]];
		end else begin
			s6_sum.total <= s5_pre[pos_q[4][6:4]];
		end
	end

	// --------------------
	// stage 7 A correction and checkpoint add
	// --------------------
	// the 15 - low masked zeros were counted as A
	assign s7_adj.total = s6_sum.total - W_OCC'(4'd15 - pos_q[5][3:0]);

	always_ff @(posedge Clk_32UI) begin
		for (int c = 0; c < N_BASE; c++) begin
			occ[c] <= cnt_q[5][c] + W_OCC'(s7_adj.lane[c]);
		end
	end

endmodule

// File: ok_compute.sv
// --------------------
// ok interval arithmetic
// aligns ik with occ counts, builds the four ok intervals and the target
// --------------------
module ok_compute import bwt_ext_pkg::*; (
	input  logic                         Clk_32UI,
	input  logic                         reset_BWT_extend,
	input  logic                         in_valid,
	input  bi_interval_t                 ik,
	input  logic [1:0]                   sel,
	input  logic [N_BASE-1:0][W_OCC-1:0] occ_k,
	input  logic [N_BASE-1:0][W_OCC-1:0] occ_l,
	input  logic [W_IDX-1:0]             primary,
	input  logic [N_BASE-1:0][W_IDX-1:0] l2,
	output logic                         wr_en,
	output ext_res_t                     wr_data
);

	localparam int BASE_A = 0;
	localparam int BASE_C = 1;
	localparam int BASE_G = 2;
	localparam int BASE_T = 3;

	// alignment with the occ pipeline
	logic [OCC_LATENCY-1:0] vld_d;
	bi_interval_t           ik_d  [OCC_LATENCY];
	logic [1:0]             sel_d [OCC_LATENCY];
	bi_interval_t           ik_a;
	logic [W_IDX-1:0]       ik_end;

	// ok stages
	logic [OK_LATENCY-1:0]     vld_s;
	logic [1:0]                sel_s [OK_LATENCY-1];
	logic                      in_range_1;
	bi_interval_t [N_BASE-1:0] ok1, ok2, ok3, ok4, ok5_n;

	// --------------------
	// valid and payload delay
	// --------------------
	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			vld_d <= '0;
			vld_s <= '0;
		end else begin
			vld_d <= {vld_d[OCC_LATENCY-2:0], in_valid};
			vld_s <= {vld_s[OK_LATENCY-2:0], vld_d[OCC_LATENCY-1]};
		end
	end

	always_ff @(posedge Clk_32UI) begin
		ik_d[0]  <= ik;
		sel_d[0] <= sel;
		for (int i = 1; i < OCC_LATENCY; i++) begin
			ik_d[i]  <= ik_d[i-1];
			sel_d[i] <= sel_d[i-1];
		end
		sel_s[0] <= sel_d[OCC_LATENCY-1];
		for (int i = 1; i < OK_LATENCY - 1; i++) begin
			sel_s[i] <= sel_s[i-1];
		end
	end

	assign ik_a   = ik_d[OCC_LATENCY-1];
	assign ik_end = ik_a.x1 + ik_a.x2 - W_IDX'(1);

	// --------------------
	// stage 1, x1 and x2 for all bases
	// --------------------
	always_ff @(posedge Clk_32UI) begin
		for (int c = 0; c < N_BASE; c++) begin
			ok1[c].x2 <= W_IDX'(occ_l[c]) - W_IDX'(occ_k[c]);
			ok1[c].x1 <= l2[c] + W_IDX'(occ_k[c]) + W_IDX'(1);
			ok1[c].x0 <= '0;
		end
		ok1[BASE_T].x0 <= ik_a.x0;
		// sentinel row inside [x1, x1 + x2 - 1]
		in_range_1 <= (ik_a.x1 <= primary) && (ik_end >= primary);
	end

	// stages 2..4, x0 chain T -> G -> C
	always_ff @(posedge Clk_32UI) begin
		ok2 <= ok1;
		ok2[BASE_T].x0 <= ok1[BASE_T].x0 + W_IDX'(in_range_1);
		ok3 <= ok2;
		ok3[BASE_G].x0 <= ok2[BASE_T].x0 + ok2[BASE_T].x2;
		ok4 <= ok3;
		ok4[BASE_C].x0 <= ok3[BASE_G].x0 + ok3[BASE_G].x2;
	end

	// stage 5, A closes the chain, target picked from the same values
	always_comb begin
		ok5_n = ok4;
		ok5_n[BASE_A].x0 = ok4[BASE_C].x0 + ok4[BASE_C].x2;
	end

	always_ff @(posedge Clk_32UI) begin
		wr_data.ok     <= ok5_n;
		wr_data.target <= ok5_n[2'd3 - sel_s[OK_LATENCY-2]];
	end

	assign wr_en = vld_s[OK_LATENCY-1];

endmodule

// File: result_fifo.sv
// --------------------
// result queue
// in-order FIFO, one credit back per result taken
// --------------------
module result_fifo import bwt_ext_pkg::*; #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic     Clk_32UI,
	input  logic     reset_BWT_extend,
	input  logic     wr_en,
	input  ext_res_t wr_data,
	input  logic     take,
	output ext_res_t rd_data,
	output logic     rd_valid,
	output logic     credit_return
);

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	ext_res_t         mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             push;
	logic             pop;

	// wrap for any depth, not only powers of two
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + PTR_W'(1);
	endfunction

	assign rd_valid      = (count != '0);
	assign pop           = take && rd_valid;
	assign push          = wr_en && (count != CNT_W'(FIFO_DEPTH));
	assign credit_return = pop;
	assign rd_data       = mem[rd_ptr];

	always_ff @(posedge Clk_32UI) begin
		if (push) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) wr_ptr <= ptr_inc(wr_ptr);
			if (pop) rd_ptr <= ptr_inc(rd_ptr);
			count <= count + CNT_W'(push) - CNT_W'(pop);
		end
	end

endmodule

// File: bwt_extend_top.sv
// --------------------
// BWT backward extension unit
// occ counts for k and l, ok arithmetic, result queue with credits
// --------------------
module bwt_extend_top import bwt_ext_pkg::*; #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic     Clk_32UI,
	input  logic     reset_BWT_extend,
	input  logic     req_valid,
	input  ext_req_t req,
	input  cfg_wr_t  cfg,
	input  logic     res_take,
	output logic     res_valid,
	output ext_res_t res,
	output logic     credit_return
);

	logic [N_BASE-1:0][W_OCC-1:0] occ_k;
	logic [N_BASE-1:0][W_OCC-1:0] occ_l;
	logic [W_IDX-1:0]             primary;
	logic [N_BASE-1:0][W_IDX-1:0] l2;
	logic                         wr_en;
	ext_res_t                     wr_data;

	ext_config u_cfg (
		.Clk_32UI         (Clk_32UI),
		.reset_BWT_extend (reset_BWT_extend),
		.cfg              (cfg),
		.primary          (primary),
		.l2               (l2)
	);

	// --------------------
	// occurrence counts, no valid, garbage flows through
	// --------------------
	occ4_count u_occ_k (
		.Clk_32UI (Clk_32UI),
		.bound    (req.k),
		.ckpt     (req.ckpt_k),
		.occ      (occ_k)
	);

	occ4_count u_occ_l (
		.Clk_32UI (Clk_32UI),
		.bound    (req.l),
		.ckpt     (req.ckpt_l),
		.occ      (occ_l)
	);

	ok_compute u_ok (
		.Clk_32UI         (Clk_32UI),
		.reset_BWT_extend (reset_BWT_extend),
		.in_valid         (req_valid),
		.ik               (req.ik),
		.sel              (req.sel),
		.occ_k            (occ_k),
		.occ_l            (occ_l),
		.primary          (primary),
		.l2               (l2),
		.wr_en            (wr_en),
		.wr_data          (wr_data)
	);

	result_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_fifo (
		.Clk_32UI         (Clk_32UI),
		.reset_BWT_extend (reset_BWT_extend),
		.wr_en            (wr_en),
		.wr_data          (wr_data),
		.take             (res_take),
		.rd_data          (res),
		.rd_valid         (res_valid),
		.credit_return    (credit_return)
	);

endmodule

// File: bwt_extend_props.sv
// --------------------
// extension unit properties
// credits, queue fill and pipeline latency
// --------------------
module bwt_ext_props import bwt_ext_pkg::*; #(
	parameter int FIFO_DEPTH = 4
) (
	input logic Clk_32UI,
	input logic reset_BWT_extend,
	input logic req_valid,
	input logic res_take,
	input logic res_valid,
	input logic credit_return,
	input logic wr_en
);
	timeunit 1ns;
	timeprecision 1ps;

	// mirrors of upstream credits and queue fill
	int credits;
	int fill;
	int prop_errors = 0;

	always_ff @(posedge Clk_32UI) begin
		if (!reset_BWT_extend) begin
			credits <= FIFO_DEPTH;
			fill    <= 0;
		end else begin
			credits <= credits - int'(req_valid) + int'(credit_return);
			fill    <= fill + int'(wr_en) - int'(credit_return);
		end
	end

	assert property (@(posedge Clk_32UI) disable iff (!reset_BWT_extend)
		req_valid |-> credits > 0)
		else begin
			prop_errors++;
			$error("request sent with no credit left");
		end

	assert property (@(posedge Clk_32UI) disable iff (!reset_BWT_extend)
		wr_en |-> fill < FIFO_DEPTH)
		else begin
			prop_errors++;
			$error("result written into a full queue");
		end

	// write trails the accepted request by the whole pipeline
	assert property (@(posedge Clk_32UI) disable iff (!reset_BWT_extend)
		wr_en == $past(req_valid, OCC_LATENCY + OK_LATENCY))
		else begin
			prop_errors++;
			$error("queue write latency broken");
		end

	// a credit comes back only for a taken result that was written before
	assert property (@(posedge Clk_32UI) disable iff (!reset_BWT_extend)
		credit_return |-> res_take && fill > 0)
		else begin
			prop_errors++;
			$error("credit returned without a result taken");
		end

endmodule

bind bwt_extend_top bwt_ext_props #(.FIFO_DEPTH(FIFO_DEPTH)) u_props (
	.Clk_32UI         (Clk_32UI),
	.reset_BWT_extend (reset_BWT_extend),
	.req_valid        (req_valid),
	.res_take         (res_take),
	.res_valid        (res_valid),
	.credit_return    (credit_return),
	.wr_en            (wr_en)
);

// File: tb_clk_gen.sv
// --------------------
// testbench clock and reset
// --------------------
module tb_clk_gen (
	output logic Clk_32UI,
	output logic reset_BWT_extend
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int RESET_CYCLES = 16;

	initial begin
		Clk_32UI = 1'b0;
		forever #5 Clk_32UI = ~Clk_32UI;
	end

	// released just after an edge, like the other inputs
	initial begin
		reset_BWT_extend = 1'b0;
		repeat (RESET_CYCLES) @(posedge Clk_32UI);
		#1 reset_BWT_extend = 1'b1;
	end

endmodule

// File: tb_bwt_extend.sv
// --------------------
// backward extension testbench
// random and directed requests against a reference model
// --------------------
module tb_bwt_extend import bwt_ext_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int FIFO_DEPTH = 4;
	localparam int N_RANDOM   = 300;
	localparam int N_DIRECTED = 19;
	localparam int MAX_CYCLES = (N_RANDOM + N_DIRECTED) * 20 + 500;

	typedef logic [N_BASE-1:0][W_OCC-1:0] occ_vec_t;

	logic     Clk_32UI;
	logic     reset_BWT_extend;
	logic     req_valid;
	logic     res_take;
	logic     res_valid;
	logic     credit_return;
	ext_req_t req;
	ext_res_t res;
	cfg_wr_t  cfg;

	integer                       seed = 32'h0e5c_e0d6;
	int                           credits;
	int                           errors = 0;
	int                           cycles = 0;
	int                           stall_left = 0;
	bit                           stall_on = 1'b0;
	logic [W_IDX-1:0]             primary_m = '0;
	logic [N_BASE-1:0][W_IDX-1:0] l2_m = '0;
	ext_res_t                     exp_q [$];

	tb_clk_gen u_clk (
		.Clk_32UI         (Clk_32UI),
		.reset_BWT_extend (reset_BWT_extend)
	);

	bwt_extend_top #(.FIFO_DEPTH(FIFO_DEPTH)) u_dut (
		.Clk_32UI         (Clk_32UI),
		.reset_BWT_extend (reset_BWT_extend),
		.req_valid        (req_valid),
		.req              (req),
		.cfg              (cfg),
		.res_take         (res_take),
		.res_valid        (res_valid),
		.res              (res),
		.credit_return    (credit_return)
	);

	// --------------------
	// reference model
	// --------------------
	function automatic logic [W_IDX-1:0] rand64();
		return {$random(seed), $random(seed)};
	endfunction

	// base p of the block in 16-base halves with the first base in the top bits
	function automatic logic [1:0] base_at(input occ_ckpt_t ck, input int p);
		logic [31:0] w;
		w = ck.bwt[(p / 16) / 2][32 * ((p / 16) % 2) +: 32];
		return w[30 - 2 * (p % 16) +: 2];
	endfunction

	function automatic occ_vec_t model_occ(input logic [W_IDX-1:0] bound,
		input occ_ckpt_t ck);
		occ_word_u n;
		occ_vec_t  o;
		n.total = '0;
		for (int p = 0; p <= int'(bound[6:0]); p++) begin
			n.lane[base_at(ck, p)] += 8'd1;
		end
		for (int c = 0; c < N_BASE; c++) begin
			o[c] = ck.cnt[c] + W_OCC'(n.lane[c]);
		end
		return o;
	endfunction

	function automatic ext_res_t model_result(input ext_req_t r);
		ext_res_t         e;
		occ_vec_t         ok_k;
		occ_vec_t         ok_l;
		logic [W_IDX-1:0] last_row;
		ok_k = model_occ(r.k, r.ckpt_k);
		ok_l = model_occ(r.l, r.ckpt_l);
		for (int c = 0; c < N_BASE; c++) begin
			e.ok[c].x2 = W_IDX'(ok_l[c]) - W_IDX'(ok_k[c]);
			e.ok[c].x1 = l2_m[c] + W_IDX'(ok_k[c]) + 64'd1;
		end
		last_row = r.ik.x1 + r.ik.x2 - 64'd1;
		if (r.ik.x1 <= primary_m && last_row >= primary_m) begin
			e.ok[3].x0 = r.ik.x0 + 64'd1;
		end else begin
			e.ok[3].x0 = r.ik.x0;
		end
		for (int c = 2; c >= 0; c--) begin
			e.ok[c].x0 = e.ok[c+1].x0 + e.ok[c+1].x2;
		end
		e.target = e.ok[3 - r.sel];
		return e;
	endfunction

	// interval kept near primary so both sides of the range show up
	function automatic ext_req_t rand_req();
		ext_req_t r;
		r.k     = rand64();
		r.l     = rand64();
		r.ik.x0 = rand64();
		r.ik.x2 = W_IDX'($unsigned($random(seed)) % 4096) + 64'd1;
		r.ik.x1 = primary_m - W_IDX'($unsigned($random(seed)) % 8192);
		for (int c = 0; c < 4; c++) begin
			r.ckpt_k.cnt[c] = $random(seed);
			r.ckpt_l.cnt[c] = $random(seed);
			r.ckpt_k.bwt[c] = rand64();
			r.ckpt_l.bwt[c] = rand64();
		end
		r.sel = 2'($random(seed));
		return r;
	endfunction

	// --------------------
	// drivers
	// --------------------
	task automatic next_cycle();
		@(posedge Clk_32UI);
		#1;
		req_valid = 1'b0;
		cfg.valid = 1'b0;
		if (stall_left > 0) begin
			stall_left--;
			res_take = 1'b0;
		end else if (stall_on && ($unsigned($random(seed)) % 6 == 0)) begin
			stall_left = $unsigned($random(seed)) % 24;
			res_take   = 1'b0;
		end else begin
			res_take = 1'b1;
		end
	endtask

	task automatic send(input ext_req_t r);
		while (credits == 0) begin
			next_cycle();
		end
		req       = r;
		req_valid = 1'b1;
		credits--;
		exp_q.push_back(model_result(r));
		next_cycle();
	endtask

	task automatic write_cfg(input logic [2:0] addr, input logic [W_IDX-1:0] data);
		cfg = '{valid: 1'b1, addr: addr, data: data};
		if (addr == 3'd0) begin
			primary_m = data;
		end else begin
			l2_m[addr - 3'd1] = data;
		end
		next_cycle();
	endtask

	// wait for an empty pipeline and queue with all credits home
	task automatic drain();
		stall_on = 1'b0;
		while (exp_q.size() != 0 || credits != FIFO_DEPTH) begin
			next_cycle();
		end
	endtask

	task automatic random_batch(input int n, input bit stall);
		drain();
		for (int a = 0; a < 5; a++) begin
			write_cfg(3'(a), rand64());
		end
		stall_on = stall;
		repeat (n) send(rand_req());
	endtask

	task automatic check_field(input string name, input logic [W_IDX-1:0] got,
		input logic [W_IDX-1:0] want);
		assert (got === want) else begin
			errors++;
			$display("[ERROR] %0t: %s got %h expected %h", $time, name, got, want);
		end
	endtask

	// --------------------
	// result checker sees the take before its edge
	// --------------------
	always @(negedge Clk_32UI) begin
		ext_res_t want;
		if (reset_BWT_extend && credit_return) begin
			credits++;
			assert (exp_q.size() != 0) else begin
				errors++;
				$display("a result came back with no request outstanding at %0t", $time);
			end
			if (exp_q.size() != 0) begin
				want = exp_q.pop_front();
				for (int c = 0; c < N_BASE; c++) begin
					check_field($sformatf("ok[%0d].x0", c), res.ok[c].x0, want.ok[c].x0);
					check_field($sformatf("ok[%0d].x1", c), res.ok[c].x1, want.ok[c].x1);
					check_field($sformatf("ok[%0d].x2", c), res.ok[c].x2, want.ok[c].x2);
				end
				check_field("target.x0", res.target.x0, want.target.x0);
				check_field("target.x1", res.target.x1, want.target.x1);
				check_field("target.x2", res.target.x2, want.target.x2);
			end
		end
	end

	always @(posedge Clk_32UI) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout after %0d cycles, %0d results missing", cycles, exp_q.size());
			$display("Testbench failed");
			$finish;
		end
	end

	// --------------------
	// test sequence
	// --------------------
	initial begin
		ext_req_t         r;
		logic [W_IDX-1:0] x1_set [4];
		logic [6:0]       low_set [5];
		int               total;
		req       = '0;
		req_valid = 1'b0;
		res_take  = 1'b1;
		cfg       = '0;
		credits   = FIFO_DEPTH;
		@(posedge reset_BWT_extend);
		repeat (8) begin
			next_cycle();
			assert (!res_valid && !credit_return) else begin
				errors++;
				$display("[ERROR] %0t: output active before any request", $time);
			end
		end

		// every sel value on one request
		r = rand_req();
		for (int s = 0; s < 4; s++) begin
			r.sel = 2'(s);
			send(r);
		end

		// primary at both range ends and one past each
		drain();
		write_cfg(3'd0, 64'h1000);
		r       = rand_req();
		r.ik.x2 = 64'd50;
		x1_set  = '{64'h1000, 64'h1000 - 64'd49, 64'h1001, 64'h1000 - 64'd50};
		for (int i = 0; i < 4; i++) begin
			r.ik.x1 = x1_set[i];
			send(r);
		end

		// bound low bits across half edges and block end
		low_set = '{7'd0, 7'd15, 7'd16, 7'd127, 7'($random(seed))};
		for (int i = 0; i < 5; i++) begin
			r         = rand_req();
			r.k[6:0]  = low_set[i];
			r.l[6:0]  = low_set[4 - i];
			send(r);
		end

		// queue fills and credits run out while the consumer stalls
		drain();
		stall_left = 40;
		res_take   = 1'b0;
		repeat (FIFO_DEPTH) send(rand_req());
		repeat (20) next_cycle();
		assert (credits == 0 && res_valid) else begin
			errors++;
			$display("[ERROR] %0t: credits %0d with a full queue", $time, credits);
		end

		// same request before and after a config rewrite
		// the interval starts just above primary so the rewrite moves it inside
		drain();
		r       = rand_req();
		r.ik.x1 = primary_m + 64'd1;
		send(r);
		drain();
		write_cfg(3'd2, rand64());
		write_cfg(3'd0, r.ik.x1);
		send(r);

		random_batch(100, 1'b0);
		random_batch(100, 1'b1);
		random_batch(N_RANDOM - 200, 1'b1);
		drain();
		repeat (4) next_cycle();

		total = errors + u_dut.u_props.prop_errors;
		$display("errors: %0d check, %0d assertion", errors, u_dut.u_props.prop_errors);
		if (total == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// File: list.f
bwt_ext_pkg.sv
ext_config.sv
occ4_count.sv
ok_compute.sv
result_fifo.sv
bwt_extend_top.sv
bwt_extend_props.sv
tb_clk_gen.sv
tb_bwt_extend.sv

// File: Bender.yml
package:
  name: bwt_extend

sources:
  - bwt_ext_pkg.sv
  - ext_config.sv
  - occ4_count.sv
  - ok_compute.sv
  - result_fifo.sv
  - bwt_extend_top.sv
  - target: test
    files:
      - bwt_extend_props.sv
      - tb_clk_gen.sv
      - tb_bwt_extend.sv
